// ==== source/fetch_params.svh ====
// Sizing constants for the instruction fetch subsystem.
// Include this wherever strand counts, FIFO depth or cache geometry are needed.

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

`define FETCH_NUM_STRANDS 4
`define FETCH_FIFO_DEPTH 4
`define ICACHE_SETS 64

// Strand s comes out of reset at s * stride
`define STRAND_PC_STRIDE 32'h1000

`endif

// ==== source/fetch_pkg.sv ====
// Types shared by the fetch stage, its FIFOs and the instruction cache.
// Refer to them by scoped name, e.g. fetch_pkg::fetch_entry_t.

`include "fetch_params.svh"

package fetch_pkg;

	// Strand number, wide enough for every strand
	typedef logic [$clog2(`FETCH_NUM_STRANDS)-1:0] strand_idx_t;

	// One fetched instruction as queued for the consumer
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instruction;	// Already byte-reversed
	} fetch_entry_t;

endpackage

// ==== source/strand_arbiter.sv ====
// Rotating arbiter for the fetch strands.
// Grants the first requester at or after the priority pointer, combinationally,
// and moves the pointer just past the winner whenever a grant is given.

`include "fetch_params.svh"

module strand_arbiter (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic [`FETCH_NUM_STRANDS-1:0] request_i,
	output logic [`FETCH_NUM_STRANDS-1:0] grant_oh_o
);

	fetch_pkg::strand_idx_t ptr_q;
	fetch_pkg::strand_idx_t winner;

	always_comb
	begin
		grant_oh_o = '0;
		winner = ptr_q;
		for (int k = `FETCH_NUM_STRANDS - 1; k >= 0; k--)
		begin
			fetch_pkg::strand_idx_t idx;
			idx = ptr_q + fetch_pkg::strand_idx_t'(k);	// Index wraps around
			if (request_i[idx])
				winner = idx;	// Scan backwards so the nearest one wins
		end
		if (|request_i)
			grant_oh_o[winner] = 1'b1;
	end

	// Winner becomes lowest priority for the next round
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			ptr_q <= '0;
		else if (|request_i)
			ptr_q <= winner + fetch_pkg::strand_idx_t'(1);
	end

endmodule

// ==== source/sync_fifo.sv ====
// Small synchronous FIFO with flush and almost-full, payload set by a type parameter.
// Enqueue and dequeue act at the clock edge; value_o always shows the head entry.

module sync_fifo #(
	parameter int  DEPTH = 4,
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     flush_i,
	input  logic     enqueue_i,
	input  payload_t value_i,
	input  logic     dequeue_i,
	output payload_t value_o,
	output logic     empty_o,
	output logic     full_o,
	output logic     almost_full_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem_q [DEPTH];
	logic [PTR_W-1:0]   rd_ptr_q;
	logic [PTR_W-1:0]   wr_ptr_q;
	logic [CNT_W-1:0]   count_q;
	logic               push;
	logic               pop;

	assign push = enqueue_i && !full_o;	// Writes into a full FIFO are dropped
	assign pop  = dequeue_i && !empty_o;

	assign empty_o       = (count_q == '0);
	assign full_o        = (count_q == CNT_W'(DEPTH));
	assign almost_full_o = (count_q == CNT_W'(DEPTH - 1));	// One slot left
	assign value_o       = mem_q[rd_ptr_q];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i || flush_i)
		begin
			rd_ptr_q <= '0;	// Flush beats a same-cycle enqueue
			wr_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			if (push && !pop)
				count_q <= count_q + 1'b1;
			else if (pop && !push)
				count_q <= count_q - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (push)
			mem_q[wr_ptr_q] <= value_i;
	end

endmodule

// ==== source/l1_icache.sv ====
// Direct-mapped L1 instruction cache with one-word lines.
// Look-up results come one cycle after the request. A miss starts a single
// refill over the memory port; a second miss meanwhile is reported as a collision.

`include "fetch_params.svh"

module l1_icache #(
	parameter int SETS = `ICACHE_SETS
) (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          request_i,
	input  logic [31:0]                   addr_i,
	input  fetch_pkg::strand_idx_t        req_strand_i,
	output logic                          hit_o,
	output logic [31:0]                   data_o,
	output logic [`FETCH_NUM_STRANDS-1:0] load_complete_strands_o,
	output logic                          load_collision_o,
	output logic                          mem_read_o,
	output logic [31:0]                   mem_addr_o,
	input  logic [31:0]                   mem_data_i,
	input  logic                          mem_valid_i
);

	localparam int INDEX_W = $clog2(SETS);
	localparam int TAG_W = 30 - INDEX_W;

	logic [SETS-1:0]         valid_q;
	logic [TAG_W-1:0]        tag_q [SETS];
	logic [31:0]             data_q [SETS];

	logic [INDEX_W-1:0]      look_idx;
	logic [TAG_W-1:0]        look_tag;
	logic                    fill_match;

	// Answer stage
	logic                    look_req_q;
	logic                    look_hit_q;
	logic [31:0]             look_addr_q;
	logic [31:0]             look_data_q;
	fetch_pkg::strand_idx_t  look_strand_q;

	// Refill engine
	logic                    busy_q;
	logic                    mem_read_q;
	logic [31:0]             fill_addr_q;
	fetch_pkg::strand_idx_t  fill_strand_q;
	logic                    start_fill;
	logic                    fill_done;
	logic [INDEX_W-1:0]      fill_idx;

	assign look_idx = addr_i[2 +: INDEX_W];
	assign look_tag = addr_i[31 -: TAG_W];
	assign fill_idx = fill_addr_q[2 +: INDEX_W];

	// Word arriving this cycle is forwarded, so a strand re-asking right away hits
	assign fill_match = fill_done && (fill_addr_q[31:2] == addr_i[31:2]);

	assign start_fill = look_req_q && !look_hit_q && !busy_q;
	assign fill_done  = busy_q && mem_valid_i;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			look_req_q <= 1'b0;
			look_hit_q <= 1'b0;
		end
		else
		begin
			look_req_q <= request_i;
			look_hit_q <= request_i && (fill_match
				|| (valid_q[look_idx] && tag_q[look_idx] == look_tag));
		end
	end

	always_ff @(posedge clk)
	begin
		look_addr_q   <= addr_i;
		look_strand_q <= req_strand_i;
		look_data_q   <= fill_match ? mem_data_i : data_q[look_idx];
	end

	assign hit_o            = look_hit_q;
	assign data_o           = look_data_q;
	assign load_collision_o = look_req_q && !look_hit_q && busy_q;

	always_comb
	begin
		load_complete_strands_o = '0;
		if (fill_done)
			load_complete_strands_o[fill_strand_q] = 1'b1;	// Wakes the waiting strand
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			busy_q     <= 1'b0;
			mem_read_q <= 1'b0;
		end
		else
		begin
			mem_read_q <= start_fill;	// One-cycle read strobe
			if (start_fill)
				busy_q <= 1'b1;
			else if (fill_done)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start_fill)
		begin
			fill_addr_q   <= look_addr_q;
			fill_strand_q <= look_strand_q;
		end
	end

	assign mem_read_o = mem_read_q;
	assign mem_addr_o = {fill_addr_q[31:2], 2'b00};

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			valid_q <= '0;
		else if (fill_done)
			valid_q[fill_idx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (fill_done)
		begin
			tag_q[fill_idx]  <= fill_addr_q[31 -: TAG_W];
			data_q[fill_idx] <= mem_data_i;
		end
	end

endmodule

// ==== source/instruction_fetch_stage.sv ====
// Fetch stage: keeps a PC per strand and issues one cache request per cycle.
// Hits are queued in the strand's instruction FIFO; misses park the strand
// until the cache reports the refill done. Rollback reloads the PC and flushes.

`include "fetch_params.svh"

module instruction_fetch_stage (
	input  logic                                clk,
	input  logic                                rst_n_i,
	output logic                                icache_request_o,
	output logic [31:0]                         icache_addr_o,
	output fetch_pkg::strand_idx_t              icache_req_strand_o,
	input  logic                                icache_hit_i,
	input  logic [31:0]                         icache_data_i,
	input  logic [`FETCH_NUM_STRANDS-1:0]       icache_load_complete_strands_i,
	input  logic                                icache_load_collision_i,
	output logic [`FETCH_NUM_STRANDS-1:0][31:0] instruction_o,
	output logic [`FETCH_NUM_STRANDS-1:0][31:0] pc_o,
	output logic [`FETCH_NUM_STRANDS-1:0]       instruction_valid_o,
	input  logic [`FETCH_NUM_STRANDS-1:0]       instruction_req_i,
	input  logic [`FETCH_NUM_STRANDS-1:0]       rollback_strand_i,
	input  logic [`FETCH_NUM_STRANDS-1:0][31:0] rollback_pc_i
);

	logic [`FETCH_NUM_STRANDS-1:0][31:0] pc_q;
	logic [`FETCH_NUM_STRANDS-1:0][31:0] pc_nxt;
	logic [`FETCH_NUM_STRANDS-1:0]       wait_q;
	logic [`FETCH_NUM_STRANDS-1:0]       wait_nxt;
	logic [`FETCH_NUM_STRANDS-1:0]       req_q;	// Strand whose answer is due now
	logic [`FETCH_NUM_STRANDS-1:0]       grant;
	logic [`FETCH_NUM_STRANDS-1:0]       offer;
	logic [`FETCH_NUM_STRANDS-1:0]       enqueue;
	logic [`FETCH_NUM_STRANDS-1:0]       full;
	logic [`FETCH_NUM_STRANDS-1:0]       almost_full;
	logic [`FETCH_NUM_STRANDS-1:0]       empty;
	logic                                miss;
	logic [31:0]                         swapped;
	fetch_pkg::strand_idx_t              grant_idx;

	// On a collision the strand does not wait but asks again
	assign miss = (|req_q) && !icache_hit_i && !icache_load_collision_i;
	assign wait_nxt = (wait_q & ~icache_load_complete_strands_i)
		| ({`FETCH_NUM_STRANDS{miss}} & req_q);

	assign enqueue = {`FETCH_NUM_STRANDS{icache_hit_i}} & req_q;

	// Room is checked against the pending enqueue so a FIFO never overflows
	assign offer = {`FETCH_NUM_STRANDS{rst_n_i}} & ~full & ~(almost_full & enqueue)
		& ~wait_nxt & ~rollback_strand_i;

	strand_arbiter u_arbiter (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.request_i  (offer),
		.grant_oh_o (grant)
	);

	always_comb
	begin
		for (int i = 0; i < `FETCH_NUM_STRANDS; i++)
		begin
			if (rollback_strand_i[i])
				pc_nxt[i] = rollback_pc_i[i];
			else if (enqueue[i])
				pc_nxt[i] = pc_q[i] + 32'd4;	// Advance only on a hit
			else
				pc_nxt[i] = pc_q[i];
		end
	end

	// One-hot grant to strand number
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < `FETCH_NUM_STRANDS; i++)
		begin
			if (grant[i])
				grant_idx = fetch_pkg::strand_idx_t'(i);
		end
	end

	// Next PC is used so a strand can follow its own hit back to back
	assign icache_request_o    = |grant;
	assign icache_addr_o       = pc_nxt[grant_idx];
	assign icache_req_strand_o = grant_idx;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < `FETCH_NUM_STRANDS; i++)
				pc_q[i] <= 32'(i) * `STRAND_PC_STRIDE;
			wait_q <= '0;
			req_q  <= '0;
		end
		else
		begin
			pc_q   <= pc_nxt;
			wait_q <= wait_nxt;
			req_q  <= grant;
		end
	end

	// Cache returns memory byte order
	assign swapped = {icache_data_i[7:0], icache_data_i[15:8],
		icache_data_i[23:16], icache_data_i[31:24]};

	for (genvar s = 0; s < `FETCH_NUM_STRANDS; s++)
	begin : g_strand
		fetch_pkg::fetch_entry_t enq_entry;
		fetch_pkg::fetch_entry_t head_entry;

		assign enq_entry.pc          = pc_q[s];	// Address that was requested
		assign enq_entry.instruction = swapped;

		sync_fifo #(
			.DEPTH     (`FETCH_FIFO_DEPTH),
			.payload_t (fetch_pkg::fetch_entry_t)
		) u_fifo (
			.clk           (clk),
			.rst_n_i       (rst_n_i),
			.flush_i       (rollback_strand_i[s]),
			.enqueue_i     (enqueue[s]),
			.value_i       (enq_entry),
			.dequeue_i     (instruction_req_i[s] && !empty[s]),
			.value_o       (head_entry),
			.empty_o       (empty[s]),
			.full_o        (full[s]),
			.almost_full_o (almost_full[s])
		);

		assign instruction_o[s] = head_entry.instruction;
		assign pc_o[s]          = head_entry.pc;
	end

	assign instruction_valid_o = ~empty;

endmodule

// ==== source/fetch_unit.sv ====
// Top of the instruction fetch subsystem.
// Joins the L1 instruction cache to the fetch stage; memory is on one side,
// the per-strand instruction consumers on the other.

`include "fetch_params.svh"

module fetch_unit (
	input  logic                                clk,
	input  logic                                rst_n_i,
	output logic                                mem_read_o,
	output logic [31:0]                         mem_addr_o,
	input  logic [31:0]                         mem_data_i,
	input  logic                                mem_valid_i,
	output logic [`FETCH_NUM_STRANDS-1:0][31:0] instruction_o,
	output logic [`FETCH_NUM_STRANDS-1:0][31:0] pc_o,
	output logic [`FETCH_NUM_STRANDS-1:0]       instruction_valid_o,
	input  logic [`FETCH_NUM_STRANDS-1:0]       instruction_req_i,
	input  logic [`FETCH_NUM_STRANDS-1:0]       rollback_strand_i,
	input  logic [`FETCH_NUM_STRANDS-1:0][31:0] rollback_pc_i
);

	logic                          icache_request;
	logic [31:0]                   icache_addr;
	fetch_pkg::strand_idx_t        icache_req_strand;
	logic                          icache_hit;
	logic [31:0]                   icache_data;
	logic [`FETCH_NUM_STRANDS-1:0] icache_load_complete_strands;
	logic                          icache_load_collision;

	l1_icache #(
		.SETS (`ICACHE_SETS)
	) u_icache (
		.clk                     (clk),
		.rst_n_i                 (rst_n_i),
		.request_i               (icache_request),
		.addr_i                  (icache_addr),
		.req_strand_i            (icache_req_strand),
		.hit_o                   (icache_hit),
		.data_o                  (icache_data),
		.load_complete_strands_o (icache_load_complete_strands),
		.load_collision_o        (icache_load_collision),
		.mem_read_o              (mem_read_o),
		.mem_addr_o              (mem_addr_o),
		.mem_data_i              (mem_data_i),
		.mem_valid_i             (mem_valid_i)
	);

	instruction_fetch_stage u_fetch (
		.clk                            (clk),
		.rst_n_i                        (rst_n_i),
		.icache_request_o               (icache_request),
		.icache_addr_o                  (icache_addr),
		.icache_req_strand_o            (icache_req_strand),
		.icache_hit_i                   (icache_hit),
		.icache_data_i                  (icache_data),
		.icache_load_complete_strands_i (icache_load_complete_strands),
		.icache_load_collision_i        (icache_load_collision),
		.instruction_o                  (instruction_o),
		.pc_o                           (pc_o),
		.instruction_valid_o            (instruction_valid_o),
		.instruction_req_i              (instruction_req_i),
		.rollback_strand_i              (rollback_strand_i),
		.rollback_pc_i                  (rollback_pc_i)
	);

endmodule

// ==== tb/fetch_assert.sv ====
// Concurrent checks bound into every instruction_fetch_stage.
// Covers the arbiter grant, the wait rule and rollback targets.

`include "fetch_params.svh"

module fetch_assert (
	input logic                                clk,
	input logic                                rst_n_i,
	input logic [`FETCH_NUM_STRANDS-1:0]       offer_i,
	input logic [`FETCH_NUM_STRANDS-1:0]       grant_i,
	input logic [`FETCH_NUM_STRANDS-1:0]       answer_i,
	input logic                                hit_i,
	input logic                                collision_i,
	input logic [`FETCH_NUM_STRANDS-1:0]       complete_i,
	input logic [`FETCH_NUM_STRANDS-1:0]       rollback_strand_i,
	input logic [`FETCH_NUM_STRANDS-1:0][31:0] rollback_pc_i
);

	int fail_count = 0;	// Failed checks so far
	logic [`FETCH_NUM_STRANDS-1:0] rollback_to_zero;
	logic [`FETCH_NUM_STRANDS-1:0] missed;	// Miss answered this cycle
	logic [`FETCH_NUM_STRANDS-1:0] parked_q;	// Missed earlier and refill not yet done

	assign missed = answer_i & {`FETCH_NUM_STRANDS{!hit_i && !collision_i}};

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			parked_q <= '0;
		else
			parked_q <= (parked_q | missed) & ~complete_i;
	end

	always_comb
	begin
		for (int s = 0; s < `FETCH_NUM_STRANDS; s++)
			rollback_to_zero[s] = rollback_strand_i[s] && (rollback_pc_i[s] == '0);
	end

	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(grant_i) && ((grant_i & ~offer_i) == '0)
		&& ((offer_i == '0) == (grant_i == '0)))
	else
	begin
		$error("arbiter grant is not one-hot, not offered, or missing");
		fail_count++;
	end

	// A strand is free again in the cycle its refill completes
	no_grant_while_waiting: assert property (@(posedge clk) disable iff (!rst_n_i)
		(grant_i & (missed | (parked_q & ~complete_i))) == '0)
	else
	begin
		$error("a waiting strand was sent to the cache");
		fail_count++;
	end

	rollback_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
		rollback_to_zero == '0)
	else
	begin
		$error("rollback to address 0");
		fail_count++;
	end

endmodule

bind instruction_fetch_stage fetch_assert u_fetch_assert (
	.clk               (clk),
	.rst_n_i           (rst_n_i),
	.offer_i           (offer),
	.grant_i           (grant),
	.answer_i          (req_q),
	.hit_i             (icache_hit_i),
	.collision_i       (icache_load_collision_i),
	.complete_i        (icache_load_complete_strands_i),
	.rollback_strand_i (rollback_strand_i),
	.rollback_pc_i     (rollback_pc_i)
);

// ==== tb/tb_fetch_unit.sv ====
// Testbench for the fetch unit with four consumers and a variable-latency memory.
// Every consumed instruction is checked against the expected per-strand stream.

`include "fetch_params.svh"

module tb_fetch_unit;

	localparam int NS = `FETCH_NUM_STRANDS;
	localparam int EXPECTED_INSNS = 4*6 + 4*12 + 3*8 + 14 + 5 + 4*4;
	localparam int CYCLE_LIMIT = 40 * EXPECTED_INSNS;
	localparam logic [31:0] LOOP_PC = 32'h0004_0100;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                mem_read;
	logic [31:0]         mem_addr;
	logic [31:0]         mem_data;
	logic                mem_valid;
	logic [NS-1:0][31:0] instruction;
	logic [NS-1:0][31:0] pc;
	logic [NS-1:0]       instruction_valid;
	logic [NS-1:0]       instruction_req;
	logic [NS-1:0]       rollback_strand;
	logic [NS-1:0][31:0] rollback_pc;

	logic [31:0]   rng = 32'h545e_005c;
	logic [NS-1:0] req_force;	// Consumer always asks
	logic [NS-1:0] req_rand;	// Consumer asks on a coin flip
	logic [31:0]   mem_pending;
	int            mem_wait;
	logic [31:0]   exp_pc [NS];
	int            consumed [NS];
	int            mem_reads;
	int            cycles;
	int            error_count;

	fetch_unit uut (
		.clk                 (clk),
		.rst_n_i             (rst_n),
		.mem_read_o          (mem_read),
		.mem_addr_o          (mem_addr),
		.mem_data_i          (mem_data),
		.mem_valid_i         (mem_valid),
		.instruction_o       (instruction),
		.pc_o                (pc),
		.instruction_valid_o (instruction_valid),
		.instruction_req_i   (instruction_req),
		.rollback_strand_i   (rollback_strand),
		.rollback_pc_i       (rollback_pc)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Memory contents are a fixed scramble of the address
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return (addr ^ 32'h5a5a_0000) + {addr[18:0], addr[31:19]};
	endfunction

	// Consumers see the memory word with its bytes reversed
	function automatic logic [31:0] expected_insn(input logic [31:0] addr);
		logic [31:0] w;
		w = mem_word(addr);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic report_error(input string msg);
		error_count++;
		$display("ERR %0t: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "stopping at the first error");
	endtask

	// Memory model and consumer requests draw from one random stream
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			mem_valid       <= 1'b0;
			mem_wait        <= 0;
			instruction_req <= '0;
		end
		else
		begin
			rng = xorshift(rng);
			mem_valid <= 1'b0;
			if (mem_wait != 0)
			begin
				assert (!mem_read)
				else report_error("memory read issued while another one is outstanding");
				mem_wait <= mem_wait - 1;
				if (mem_wait == 1)
				begin
					mem_valid <= 1'b1;
					mem_data  <= mem_word(mem_pending);
				end
			end
			else if (mem_read)
			begin
				mem_pending <= mem_addr;
				mem_wait    <= 1 + int'(rng[2:0]) % 6;	// 1 to 6 cycles
			end
			instruction_req <= req_force | (req_rand & rng[11:8]);
		end
	end

	// Scoreboard
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < NS; s++)
				exp_pc[s] = 32'(s) * `STRAND_PC_STRIDE;
		end
		else
		begin
			if (mem_read)
				mem_reads <= mem_reads + 1;
			for (int s = 0; s < NS; s++)
			begin
				if (instruction_req[s] && instruction_valid[s])
				begin
					assert (pc[s] == exp_pc[s] && instruction[s] == expected_insn(exp_pc[s]))
					else report_error($sformatf("strand %0d pc %h insn %h, expected pc %h insn %h",
						s, pc[s], instruction[s], exp_pc[s], expected_insn(exp_pc[s])));
					exp_pc[s] = exp_pc[s] + 32'd4;
					consumed[s] <= consumed[s] + 1;
				end
				if (rollback_strand[s])
					exp_pc[s] = rollback_pc[s];	// Dequeue in this cycle was still the old stream
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (uut.u_fetch.u_fetch_assert.fail_count != 0)
		begin
			$display("A concurrent assertion on the fetch stage failed");
			$display("Errors found");
			$fatal(1, "stopping after an assertion failure");
		end
		else if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, not all instructions arrived", cycles);
			$display("Errors found");
			$fatal(1, "stopping on timeout");
		end
	end

	// Wait until every strand in mask has consumed extra more words
	task automatic run_until(input logic [NS-1:0] mask, input int extra);
		int start [NS];
		logic done;
		for (int s = 0; s < NS; s++)
			start[s] = consumed[s];
		done = 1'b0;
		while (!done)
		begin
			@(posedge clk);
			done = 1'b1;
			for (int s = 0; s < NS; s++)
				if (mask[s] && consumed[s] < start[s] + extra)
					done = 1'b0;
		end
	endtask

	task automatic wait_full(input logic [NS-1:0] mask);
		while ((uut.u_fetch.full & mask) != mask)
			@(posedge clk);
	endtask

	task automatic rollback(input int s, input logic [31:0] target);
		@(posedge clk);
		rollback_strand[s] <= 1'b1;
		rollback_pc[s]     <= target;
		@(posedge clk);
		rollback_strand[s] <= 1'b0;
	endtask

	initial
	begin
		int reads_before;
		rst_n           = 1'b0;
		mem_data        = '0;
		mem_valid       = 1'b0;
		instruction_req = '0;
		rollback_strand = '0;
		rollback_pc     = '0;
		req_force       = '0;
		req_rand        = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		assert (instruction_valid == '0 && mem_read == 1'b0)
		else report_error("valid or memory read active right after reset");

		// In-order streams from the reset PCs
		req_force <= '1;
		run_until('1, 6);

		req_force <= '0;
		req_rand  <= '1;
		run_until('1, 12);

		// Strand 2 stalls until its FIFO is full while the others keep going
		req_rand <= 4'b1011;
		wait_full(4'b0100);
		run_until(4'b1011, 8);
		assert (uut.u_fetch.full[2] && instruction_valid[2])
		else report_error("stalled strand 2 no longer holds a full FIFO");

		// Strand 1 runs alone while the others sit on full FIFOs
		req_rand  <= '0;
		req_force <= 4'b0010;
		wait_full(4'b1101);
		rollback(1, LOOP_PC);
		run_until(4'b0010, 14);

		// Running the same code again must hit in the cache on every fetch
		rollback(1, LOOP_PC);
		repeat (2) @(posedge clk);
		reads_before = mem_reads;
		run_until(4'b0010, 5);
		assert (mem_reads == reads_before)
		else report_error("loop fetched from memory instead of hitting in the cache");

		req_force <= '0;
		req_rand  <= '1;
		run_until('1, 4);

		if (error_count == 0 && uut.u_fetch.u_fetch_assert.fail_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+source
source/fetch_pkg.sv
source/strand_arbiter.sv
source/sync_fifo.sv
source/l1_icache.sv
source/instruction_fetch_stage.sv
source/fetch_unit.sv
tb/fetch_assert.sv
tb/tb_fetch_unit.sv

// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/strand_arbiter.sv
      - source/sync_fifo.sv
      - source/l1_icache.sv
      - source/instruction_fetch_stage.sv
      - source/fetch_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/fetch_assert.sv
      - tb/tb_fetch_unit.sv
